//--- sources.f
+incdir+verilog
verilog/slc3_pkg.sv
verilog/ctrlIf.sv
verilog/controlFsm.sv
verilog/memWaitTimer.sv
verilog/datapath.sv
verilog/ioBridge.sv
verilog/slc3.sv
tests/slc3_assertions.sv
tests/slc3_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the SLC-3 testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module slc3_tb \
    -f sources.f -o slc3_sim > build.log 2>&1 &&
./obj_dir/slc3_sim > sim.log 2>&1
grep -q "^Test OK$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tests/slc3_tb.sv
//------------------------------------------------------------
// SLC-3 testbench
// Memory model, program image, reference model and checks
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slc3_consts.svh"

module slc3_tb;

    localparam logic [15:0] HaltWord = 16'h0FFF;

    logic Clk, rst, run, cont;
    logic [15:0] switches, memRdata, memAddr, memWdata, pc, hexOut;
    logic [11:0] led;
    logic memOe, memWe;
    logic [15:0] mem [65536];
    logic [15:0] mm [65536];
    logic [15:0] hexQ [$];
    logic [31:0] wrQ [$];
    logic [11:0] ledQ [$];
    logic [31:0] seed;
    logic [15:0] hexGot, hexExp, haltAddr;
    logic [31:0] wrGot, wrExp;
    logic [11:0] ledExp;
    logic hexChk, wrChk, rstSettled, pauseHold;
    int   weCnt, p;

    slc3 slc3_inst (.*);

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [2:0] ccOf(input logic [15:0] v);
        return {v[15], v == 16'h0, !v[15] && (v != 16'h0)};
    endfunction

    // Tiny assembler
    function automatic logic [15:0] encReg(input int op, dr, sa, sb);
        return {op[3:0], dr[2:0], sa[2:0], 3'b000, sb[2:0]};
    endfunction
    function automatic logic [15:0] encImm(input int op, dr, sa, imm);
        return {op[3:0], dr[2:0], sa[2:0], 1'b1, imm[4:0]};
    endfunction
    function automatic logic [15:0] encMem(input int op, r, base, off);
        return {op[3:0], r[2:0], base[2:0], off[5:0]};
    endfunction
    function automatic logic [15:0] encBr(input int nzp, off);
        return {4'b0000, nzp[2:0], off[8:0]};
    endfunction

    task automatic emit(input logic [15:0] w);
        mem[p] = w;
        p++;
    endtask

    task automatic failWithError(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic timeoutAbort(input string msg);
        $display("Timed out while waiting for %s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic stepCycles(input int n);
        repeat (n) @(posedge Clk);
        #1;
    endtask

    //------------------------------------------------------------
    // Program image
    //------------------------------------------------------------
    task automatic buildProgram;
        p = 0;
        // R6 = IO_ADDR
        emit(encImm(5, 6, 6, 0));
        emit(encImm(1, 6, 6, -1));
        // Switches to hex
        emit(encMem(6, 1, 6, 0));
        emit(encMem(7, 1, 6, 0));
        emit(encMem(6, 2, 6, -16));
        emit(encMem(6, 3, 6, -15));
        emit(encReg(1, 4, 2, 3));
        emit(encMem(7, 4, 6, 0));
        emit(encReg(5, 4, 2, 3));
        emit(encMem(7, 4, 6, 0));
        // NOT R4, R2
        emit(16'h98BF);
        emit(encMem(7, 4, 6, 0));
        emit(encImm(1, 4, 2, -7));
        emit(encMem(7, 4, 6, 0));
        emit(encImm(5, 4, 3, 13));
        emit(encMem(7, 4, 6, 0));
        // Round trip through ordinary memory
        emit(encMem(7, 4, 6, -14));
        emit(encMem(6, 5, 6, -14));
        emit(encMem(7, 5, 6, 0));
        // Branches, markers counted up in R0
        emit(encImm(5, 0, 0, 0));
        emit(encBr(3'b010, 1));
        emit(encImm(1, 0, 0, 9));
        emit(encImm(1, 0, 0, 1));
        emit(encMem(7, 0, 6, 0));
        emit(encBr(3'b100, 1));
        emit(encImm(1, 0, 0, 2));
        emit(encMem(7, 0, 6, 0));
        // NOT R4, R0 leaves N set for BRp and BRn
        emit(16'h983F);
        emit(encBr(3'b001, 1));
        emit(encBr(3'b100, 1));
        emit(encImm(1, 0, 0, 5));
        emit(encImm(1, 0, 0, 1));
        emit(encMem(7, 0, 6, 0));
        emit(encBr(3'b010, 1));
        emit(encImm(1, 0, 0, 1));
        emit(encMem(7, 0, 6, 0));
        // P still set from the add
        emit(encBr(3'b001, 1));
        emit(encImm(1, 0, 0, 9));
        // JSR, return through R7, then JMP over a word
        emit(16'h4803);
        emit(encImm(1, 0, 0, 1));
        emit(encMem(7, 0, 6, 0));
        emit(encBr(3'b111, 3));
        emit(encImm(1, 0, 0, 3));
        emit(encMem(7, 0, 6, 0));
        emit(16'hC1C0);
        emit(encImm(1, 5, 7, 9));
        emit(16'hC140);
        emit(encImm(1, 0, 0, 7));
        emit(encImm(1, 0, 0, 1));
        emit(encMem(7, 0, 6, 0));
        emit(16'hD5A3);
        emit(encImm(1, 0, 0, 1));
        emit(encMem(7, 0, 6, 0));
        emit(HaltWord);
    endtask

    //------------------------------------------------------------
    // Instruction-level reference model
    //------------------------------------------------------------
    task automatic runModel;
        logic [15:0] r [8];
        logic [15:0] ir, mpc, a, t;
        logic [2:0]  nzp;
        int          steps;
        mpc = 16'h0;
        nzp = 3'b000;
        steps = 0;
        for (int i = 0; i < 8; i++) r[i] = 16'h0;
        for (int i = 0; i < 65536; i++) mm[i] = mem[i];
        while (mm[mpc] != HaltWord && steps < 1000) begin
            ir = mm[mpc];
            mpc = mpc + 16'h1;
            steps++;
            a = r[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
            t = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
            case (ir[15:12])
                4'b0001: begin
                    r[ir[11:9]] = r[ir[8:6]] + t;
                    nzp = ccOf(r[ir[11:9]]);
                end
                4'b0101: begin
                    r[ir[11:9]] = r[ir[8:6]] & t;
                    nzp = ccOf(r[ir[11:9]]);
                end
                4'b1001: begin
                    r[ir[11:9]] = ~r[ir[8:6]];
                    nzp = ccOf(r[ir[11:9]]);
                end
                4'b0000: if ((ir[11:9] & nzp) != 3'b000) mpc = mpc + {{7{ir[8]}}, ir[8:0]};
                4'b1100: mpc = r[ir[8:6]];
                4'b0100: begin
                    t = mpc;
                    mpc = ir[11] ? mpc + {{5{ir[10]}}, ir[10:0]} : r[ir[8:6]];
                    r[7] = t;
                end
                4'b0110: begin
                    r[ir[11:9]] = (a == `IO_ADDR) ? switches : mm[a];
                    nzp = ccOf(r[ir[11:9]]);
                end
                4'b0111: begin
                    if (a == `IO_ADDR) begin
                        hexQ.push_back(r[ir[11:9]]);
                    end else begin
                        mm[a] = r[ir[11:9]];
                        wrQ.push_back({a, r[ir[11:9]]});
                    end
                end
                4'b1101: ledQ.push_back(ir[11:0]);
                default: ;
            endcase
        end
        haltAddr = mpc;
    endtask

    //------------------------------------------------------------
    // Memory model and access monitors
    //------------------------------------------------------------
    assign memRdata = memOe ? mem[memAddr] : 16'h0;

    always @(posedge Clk) begin
        hexChk <= 1'b0;
        wrChk  <= 1'b0;
        weCnt  <= slc3_inst.cpuWe ? weCnt + 1 : 0;
        // Last cycle of an I/O store, external strobe stays low
        if (slc3_inst.cpuWe && weCnt == `MEM_WAIT && memAddr == `IO_ADDR) begin
            hexChk <= 1'b1;
            hexGot <= hexOut;
            hexExp <= (hexQ.size() > 0) ? hexQ.pop_front() : ~hexOut;
        end
        // Last cycle of memWe
        if (memWe && weCnt == `MEM_WAIT) begin
            mem[memAddr] = memWdata;
            wrChk <= 1'b1;
            wrGot <= {memAddr, memWdata};
            wrExp <= (wrQ.size() > 0) ? wrQ.pop_front() : ~{memAddr, memWdata};
        end
    end

    resetQuiet: assert property (@(posedge Clk) rstSettled |->
        (!memOe && !memWe && pc == 16'h0 && led == 12'h0 && hexOut == 16'h0))
        else failWithError("outputs not idle in reset");
    hexMatch: assert property (@(posedge Clk) disable iff (rst) hexChk |-> hexGot == hexExp)
        else failWithError($sformatf("hexOut %h, expected %h", hexGot, hexExp));
    wrMatch: assert property (@(posedge Clk) disable iff (rst) wrChk |-> wrGot == wrExp)
        else failWithError($sformatf("write %h, expected %h", wrGot, wrExp));
    pauseMatch: assert property (@(posedge Clk) disable iff (rst)
        pauseHold |-> (led == ledExp && $stable(pc)))
        else failWithError($sformatf("pause led %h pc %h, expected led %h", led, pc, ledExp));

    //------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------
    initial begin
        int t;
        rst = 1'b1;
        run = 1'b0;
        cont = 1'b0;
        rstSettled = 1'b0;
        pauseHold = 1'b0;
        seed = 32'h51d767db;
        for (int i = 0; i < 65536; i++) mem[i] = {i[7:0], i[15:8]} ^ 16'h5A5A;
        seed = xorshift(seed);
        switches = seed[15:0];
        seed = xorshift(seed);
        mem[16'hFFEF] = seed[15:0];
        seed = xorshift(seed);
        mem[16'hFFF0] = seed[31:16];
        buildProgram();
        runModel();
        stepCycles(2);
        rstSettled = 1'b1;
        stepCycles(14);
        rst = 1'b0;
        stepCycles(10);
        rstSettled = 1'b0;
        run = 1'b1;
        // Pause entry
        for (t = 0; t < 2000 && led == 12'h0; t++) stepCycles(1);
        if (led == 12'h0) timeoutAbort("the PAUSE instruction");
        if (ledQ.size() == 0) failWithError("unexpected PAUSE");
        ledExp = ledQ.pop_front();
        pauseHold = 1'b1;
        stepCycles(12);
        cont = 1'b1;
        stepCycles(3);
        cont = 1'b0;
        pauseHold = 1'b0;
        // Remaining accesses and the halt loop
        for (t = 0; t < 2000 && (hexQ.size() > 0 || wrQ.size() > 0); t++) stepCycles(1);
        if (hexQ.size() > 0 || wrQ.size() > 0) timeoutAbort("the expected memory writes");
        for (t = 0; t < 200 && pc != haltAddr; t++) stepCycles(1);
        if (pc != haltAddr) timeoutAbort("the halt loop");
        stepCycles(10);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/slc3_assertions.sv
//------------------------------------------------------------
// SLC-3 memory protocol and I/O checks, bound to the top level
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slc3_consts.svh"

module slc3_assertions (
    input logic               Clk,
    input logic               rst,
    input logic               memOe,
    input logic               memWe,
    input logic [`WORD_W-1:0] memAddr,
    input logic [`WORD_W-1:0] hexOut
);

    // Read and write strobes are exclusive
    strobeExclusive: assert property (@(posedge Clk) disable iff (rst)
        !(memOe && memWe)) else $error("memOe and memWe high together");

    // Address held for the whole access
    addrStable: assert property (@(posedge Clk) disable iff (rst)
        ((memOe && $past(memOe)) || (memWe && $past(memWe))) |-> $stable(memAddr))
        else $error("memAddr moved during an access");

    // Strobe width of MEM_WAIT plus 1 cycles
    oeWidth: assert property (@(posedge Clk) disable iff (rst)
        $rose(memOe) |-> memOe [*(`MEM_WAIT + 1)] ##1 !memOe)
        else $error("memOe width wrong");
    weWidth: assert property (@(posedge Clk) disable iff (rst)
        $rose(memWe) |-> memWe [*(`MEM_WAIT + 1)] ##1 !memWe)
        else $error("memWe width wrong");

    // No external write to the I/O address
    noIoWrite: assert property (@(posedge Clk) disable iff (rst)
        $rose(memWe) |-> memAddr != `IO_ADDR) else $error("memWe at IO_ADDR");

    // Display only changes on an I/O access
    hexOnIo: assert property (@(posedge Clk) disable iff (rst)
        $changed(hexOut) |-> memAddr == `IO_ADDR) else $error("hexOut changed off IO_ADDR");

endmodule

bind slc3 slc3_assertions slc3Assert_inst (.*);

`default_nettype wire

//--- verilog/slc3.sv
//------------------------------------------------------------
// SLC-3 top level
// Sequencer, wait timer, datapath and I/O bridge
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slc3_consts.svh"

// Hex decoders left out, raw display word and PC come out instead.
// Split read and write data ports stand in for the tristate bus.
// Strobes and buttons are active high, no CE, UB or LB.
module slc3 (
    input  logic               Clk,
    input  logic               rst,
    input  logic               run,
    input  logic               cont,
    input  logic [`WORD_W-1:0] switches,
    input  logic [`WORD_W-1:0] memRdata,
    output logic [`WORD_W-1:0] memAddr,
    output logic [`WORD_W-1:0] memWdata,
    output logic [`WORD_W-1:0] pc,
    output logic [`WORD_W-1:0] hexOut,
    output logic [11:0]        led,
    output logic               memOe,
    output logic               memWe
);

    ctrlIf ctrl ();

    logic               timerStart, timerDone;
    logic               cpuWe;
    logic [`WORD_W-1:0] cpuRdata;

    controlFsm controlFsm_inst (
        .Clk(Clk), .rst(rst), .run(run), .cont(cont), .ctrl(ctrl.fsm),
        .timerDone(timerDone), .timerStart(timerStart), .memOe(memOe), .memWe(cpuWe)
    );

    memWaitTimer memWaitTimer_inst (
        .Clk(Clk), .rst(rst), .start(timerStart), .done(timerDone)
    );

    // 16-bit address space, MAR drives memory directly
    datapath datapath_inst (
        .Clk(Clk), .rst(rst), .ctrl(ctrl.dp), .memData(cpuRdata),
        .mar(memAddr), .mdr(memWdata), .pc(pc), .led(led)
    );

    ioBridge ioBridge_inst (
        .Clk(Clk), .rst(rst), .cpuOe(memOe), .cpuWe(cpuWe), .addr(memAddr),
        .cpuWdata(memWdata), .switches(switches), .memRdata(memRdata),
        .cpuRdata(cpuRdata), .memWe(memWe), .hexOut(hexOut)
    );

endmodule

`default_nettype wire

//--- verilog/ioBridge.sv
//------------------------------------------------------------
// Memory-mapped I/O at IO_ADDR
// Switches on reads, hex display register on writes
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slc3_consts.svh"

module ioBridge (
    input  logic               Clk,
    input  logic               rst,
    input  logic               cpuOe,
    input  logic               cpuWe,
    input  logic [`WORD_W-1:0] addr,
    input  logic [`WORD_W-1:0] cpuWdata,
    input  logic [`WORD_W-1:0] switches,
    input  logic [`WORD_W-1:0] memRdata,
    output logic [`WORD_W-1:0] cpuRdata,
    output logic               memWe,
    output logic [`WORD_W-1:0] hexOut
);

    logic ioHit;
    logic weDly;

    // The only address decode in the design
    assign ioHit    = (addr == `IO_ADDR);
    assign cpuRdata = (cpuOe && ioHit) ? switches : memRdata;
    // I/O writes never reach external memory
    assign memWe    = cpuWe && !ioHit;

    // Write data settles one cycle into the access
    always_ff @(posedge Clk) begin
        if (rst) begin
            weDly  <= 1'b0;
            hexOut <= '0;
        end else begin
            weDly <= cpuWe;
            if (cpuWe && weDly && ioHit)
                hexOut <= cpuWdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/datapath.sv
//------------------------------------------------------------
// SLC-3 datapath
// PC, MAR, MDR, IR, register file, ALU, address adder, NZP
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slc3_consts.svh"

module datapath import slc3_pkg::*; (
    input  logic                Clk,
    input  logic                rst,
    ctrlIf.dp                   ctrl,
    input  logic [`WORD_W-1:0]  memData,
    output logic [`WORD_W-1:0]  mar,
    output logic [`WORD_W-1:0]  mdr,
    output logic [`WORD_W-1:0]  pc,
    output logic [11:0]         led
);

    localparam int IdxW = $clog2(`REG_COUNT);

    logic [`WORD_W-1:0] regs [`REG_COUNT];
    logic [`WORD_W-1:0] irQ;
    logic [2:0]         nzp;
    logic [IdxW-1:0]    aIdx, drIdx;
    logic [`WORD_W-1:0] baseVal, aluA, aluB, aluOut;
    logic [`WORD_W-1:0] addr1, addr2, adderOut;
    logic [`WORD_W-1:0] bus, pcNext;

    assign ctrl.ir = irQ;

    //------------------------------------------------------------
    // Register reads and ALU
    //------------------------------------------------------------
    // Pass A reads the store source IR[11:9] instead of SR1
    assign aIdx    = (ctrl.aluOp == ALU_PASSA) ? irQ[11:9] : irQ[8:6];
    assign drIdx   = ctrl.drSel ? IdxW'(`REG_COUNT - 1) : irQ[11:9];
    assign baseVal = regs[irQ[8:6]];
    assign aluA    = regs[aIdx];
    // IR[5] selects imm5 over SR2
    assign aluB    = irQ[5] ? {{(`WORD_W-5){irQ[4]}}, irQ[4:0]} : regs[irQ[2:0]];

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: aluOut = aluA + aluB;
            ALU_AND: aluOut = aluA & aluB;
            ALU_NOT: aluOut = ~aluA;
            default: aluOut = aluA;
        endcase
    end

    // Address adder
    assign addr1 = ctrl.addr1Sel ? baseVal : pc;

    always_comb begin
        case (ctrl.addr2Sel)
            ADDR2_OFF6:  addr2 = {{(`WORD_W-6){irQ[5]}}, irQ[5:0]};
            ADDR2_OFF9:  addr2 = {{(`WORD_W-9){irQ[8]}}, irQ[8:0]};
            ADDR2_OFF11: addr2 = {{(`WORD_W-11){irQ[10]}}, irQ[10:0]};
            default:     addr2 = '0;
        endcase
    end

    assign adderOut = addr1 + addr2;

    // Single internal bus
    always_comb begin
        case (ctrl.busSel)
            BUS_MDR:  bus = mdr;
            BUS_ALU:  bus = aluOut;
            BUS_ADDR: bus = adderOut;
            default:  bus = pc;
        endcase
    end

    always_comb begin
        case (ctrl.pcSel)
            PC_ADDER: pcNext = adderOut;
            PC_BASE:  pcNext = baseVal;
            default:  pcNext = pc + `WORD_W'(1);
        endcase
    end

    //------------------------------------------------------------
    // Registers
    //------------------------------------------------------------
    always_ff @(posedge Clk) begin
        if (rst) begin
            pc       <= '0;
            led      <= '0;
            nzp      <= '0;
            ctrl.ben <= 1'b0;
        end else begin
            if (ctrl.ldPc)  pc  <= pcNext;
            if (ctrl.ldLed) led <= irQ[11:0];
            // N, Z, P from the value on the bus
            if (ctrl.ldCc)
                nzp <= {bus[`WORD_W-1], bus == '0, !bus[`WORD_W-1] && (bus != '0)};
            if (ctrl.ldBen) ctrl.ben <= |(irQ[11:9] & nzp);
        end
    end

    always_ff @(posedge Clk) begin
        if (ctrl.ldMar) mar <= bus;
        if (ctrl.ldMdr) mdr <= ctrl.mdrSel ? memData : bus;
        if (ctrl.ldIr)  irQ <= bus;
        if (ctrl.ldReg) regs[drIdx] <= bus;
    end

endmodule

`default_nettype wire

//--- verilog/memWaitTimer.sv
//------------------------------------------------------------
// Memory access wait timer
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slc3_consts.svh"

module memWaitTimer (
    input  logic Clk,
    input  logic rst,
    input  logic start,
    output logic done
);

    localparam int CntW = $clog2(`MEM_WAIT + 1);

    logic [CntW-1:0] count;

    // Restart reloads even mid-count
    always_ff @(posedge Clk) begin
        if (rst)
            count <= '0;
        else if (start)
            count <= CntW'(`MEM_WAIT);
        else if (count != '0)
            count <= count - CntW'(1);
    end

    // Final count, MEM_WAIT cycles after start
    assign done = (count == CntW'(1));

endmodule

`default_nettype wire

//--- verilog/controlFsm.sv
//------------------------------------------------------------
// SLC-3 instruction sequencer
// Fetch, decode, per-opcode execute paths and pause
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module controlFsm import slc3_pkg::*; (
    input  logic Clk,
    input  logic rst,
    input  logic run,
    input  logic cont,
    ctrlIf.fsm   ctrl,
    input  logic timerDone,
    output logic timerStart,
    output logic memOe,
    output logic memWe
);

    typedef enum logic [4:0] {
        S_HALT, S_FETCH1, S_FETCH2, S_FETCH3, S_DECODE,
        S_ADD, S_AND, S_NOT, S_BR, S_JMP, S_JSR1, S_JSR2,
        S_LDR1, S_LDR2, S_STR1, S_STR2, S_PAUSE1, S_PAUSE2
    } stateT;

    stateT state, nextState;
    logic  memState;
    logic  accActive;

    // Memory access states hold their strobe until the timer fires
    assign memState   = (state == S_FETCH2) || (state == S_LDR2) || (state == S_STR2);
    assign timerStart = memState && !accActive;
    assign memOe      = (state == S_FETCH2) || (state == S_LDR2);
    assign memWe      = (state == S_STR2);

    always_ff @(posedge Clk) begin
        if (rst) begin
            state     <= S_HALT;
            accActive <= 1'b0;
        end else begin
            state <= nextState;
            // High from the second cycle of an access to its last
            if (timerDone)
                accActive <= 1'b0;
            else if (timerStart)
                accActive <= 1'b1;
        end
    end

    //------------------------------------------------------------
    // Next state
    //------------------------------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            S_HALT:   if (run) nextState = S_FETCH1;
            S_FETCH1: nextState = S_FETCH2;
            S_FETCH2: if (timerDone) nextState = S_FETCH3;
            S_FETCH3: nextState = S_DECODE;
            S_DECODE: begin
                case (opcodeT'(ctrl.ir[15:12]))
                    OP_ADD:   nextState = S_ADD;
                    OP_AND:   nextState = S_AND;
                    OP_NOT:   nextState = S_NOT;
                    OP_BR:    nextState = S_BR;
                    OP_JMP:   nextState = S_JMP;
                    OP_JSR:   nextState = S_JSR1;
                    OP_LDR:   nextState = S_LDR1;
                    OP_STR:   nextState = S_STR1;
                    OP_PAUSE: nextState = S_PAUSE1;
                    // Unsupported opcodes act as no-ops
                    default:  nextState = S_FETCH1;
                endcase
            end
            S_JSR1:   nextState = S_JSR2;
            S_LDR1:   nextState = S_LDR2;
            S_STR1:   nextState = S_STR2;
            S_LDR2, S_STR2: if (timerDone) nextState = S_FETCH1;
            S_PAUSE1: if (cont) nextState = S_PAUSE2;
            S_PAUSE2: if (!cont) nextState = S_FETCH1;
            default:  nextState = S_FETCH1;
        endcase
    end

    //------------------------------------------------------------
    // Strobes and selects per state
    //------------------------------------------------------------
    always_comb begin
        ctrl.ldMar    = 1'b0;
        ctrl.ldMdr    = 1'b0;
        ctrl.ldIr     = 1'b0;
        ctrl.ldBen    = 1'b0;
        ctrl.ldCc     = 1'b0;
        ctrl.ldReg    = 1'b0;
        ctrl.ldPc     = 1'b0;
        ctrl.ldLed    = 1'b0;
        ctrl.busSel   = BUS_PC;
        ctrl.pcSel    = PC_INC;
        ctrl.addr1Sel = 1'b0;
        ctrl.addr2Sel = ADDR2_ZERO;
        ctrl.drSel    = 1'b0;
        ctrl.aluOp    = ALU_ADD;
        ctrl.mdrSel   = 1'b0;
        case (state)
            S_FETCH1: begin
                // MAR <= PC, PC <= PC + 1
                ctrl.ldMar = 1'b1;
                ctrl.ldPc  = 1'b1;
            end
            S_FETCH2: begin
                // Sample read data once it is valid
                ctrl.ldMdr  = accActive;
                ctrl.mdrSel = 1'b1;
            end
            S_FETCH3: begin
                ctrl.busSel = BUS_MDR;
                ctrl.ldIr   = 1'b1;
            end
            S_DECODE: ctrl.ldBen = 1'b1;
            S_ADD, S_AND, S_NOT: begin
                ctrl.busSel = BUS_ALU;
                ctrl.aluOp  = (state == S_ADD) ? ALU_ADD :
                              (state == S_AND) ? ALU_AND : ALU_NOT;
                ctrl.ldReg  = 1'b1;
                ctrl.ldCc   = 1'b1;
            end
            S_BR: begin
                ctrl.pcSel    = PC_ADDER;
                ctrl.addr2Sel = ADDR2_OFF9;
                ctrl.ldPc     = ctrl.ben;
            end
            S_JMP: begin
                ctrl.pcSel = PC_BASE;
                ctrl.ldPc  = 1'b1;
            end
            S_JSR1: begin
                // Link address into R7
                ctrl.drSel = 1'b1;
                ctrl.ldReg = 1'b1;
            end
            S_JSR2: begin
                // IR[11] picks JSR offset over JSRR base
                ctrl.pcSel    = ctrl.ir[11] ? PC_ADDER : PC_BASE;
                ctrl.addr2Sel = ADDR2_OFF11;
                ctrl.ldPc     = 1'b1;
            end
            S_LDR1, S_STR1: begin
                // MAR <= base + offset6
                ctrl.busSel   = BUS_ADDR;
                ctrl.addr1Sel = 1'b1;
                ctrl.addr2Sel = ADDR2_OFF6;
                ctrl.ldMar    = 1'b1;
            end
            S_LDR2: begin
                // MDR holds valid data by the last cycle, written back then
                ctrl.ldMdr  = accActive;
                ctrl.mdrSel = 1'b1;
                ctrl.busSel = BUS_MDR;
                ctrl.ldReg  = timerDone;
                ctrl.ldCc   = timerDone;
            end
            S_STR2: begin
                // Store data into MDR in the first write cycle
                ctrl.busSel = BUS_ALU;
                ctrl.aluOp  = ALU_PASSA;
                ctrl.ldMdr  = timerStart;
            end
            S_PAUSE1: ctrl.ldLed = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/ctrlIf.sv
//------------------------------------------------------------
// Control bundle between the FSM and the datapath
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slc3_consts.svh"

interface ctrlIf import slc3_pkg::*; ();

    // Register load strobes, one cycle each
    logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;

    // Bus source and mux selects
    busSelT   busSel;
    pcSelT    pcSel;
    logic     addr1Sel;   // 0 PC, 1 base register
    addr2SelT addr2Sel;
    logic     drSel;      // 0 IR[11:9], 1 R7
    aluOpT    aluOp;
    logic     mdrSel;     // 0 bus, 1 memory

    // Status back to the FSM
    logic [`WORD_W-1:0] ir;
    logic               ben;

    modport fsm (
        output ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed,
        output busSel, pcSel, addr1Sel, addr2Sel, drSel, aluOp, mdrSel,
        input  ir, ben
    );

    modport dp (
        input  ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed,
        input  busSel, pcSel, addr1Sel, addr2Sel, drSel, aluOp, mdrSel,
        output ir, ben
    );

endinterface

`default_nettype wire

//--- verilog/slc3_pkg.sv
//------------------------------------------------------------
// SLC-3 shared types
// Opcodes, bus and mux selects, ALU functions
//------------------------------------------------------------
`default_nettype none

package slc3_pkg;

    // Supported LC-3 opcodes, original encodings
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ADD   = 4'b0001,
        OP_JSR   = 4'b0100,
        OP_AND   = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_NOT   = 4'b1001,
        OP_JMP   = 4'b1100,
        OP_PAUSE = 4'b1101
    } opcodeT;

    // Next PC source
    typedef enum logic [1:0] {PC_INC, PC_ADDER, PC_BASE} pcSelT;

    // ALU function, PASSA forwards the store source register
    typedef enum logic [1:0] {ALU_ADD, ALU_AND, ALU_NOT, ALU_PASSA} aluOpT;

    // Second address adder operand, all sign-extended from IR
    typedef enum logic [1:0] {ADDR2_ZERO, ADDR2_OFF6, ADDR2_OFF9, ADDR2_OFF11} addr2SelT;

    // Driver of the internal bus
    typedef enum logic [1:0] {BUS_PC, BUS_MDR, BUS_ALU, BUS_ADDR} busSelT;

endpackage

`default_nettype wire

//--- verilog/slc3_consts.svh
//------------------------------------------------------------
// SLC-3 sizing and address constants
//------------------------------------------------------------
`ifndef SLC3_CONSTS_SVH
`define SLC3_CONSTS_SVH

// Data and address width
`define WORD_W 16

// General purpose registers R0..R7
`define REG_COUNT 8

// Cycles a strobe is held before data is taken
`define MEM_WAIT 2

// Switches on read, hex display on write
`define IO_ADDR 16'hFFFF

`endif
